// ==== all.f ====
hw/adam_ctrl_pkg.sv
hw/ps2_key_pkg.sv
hw/ps2_keypad_emu.sv
hw/ctrl_port_encoder.sv
hw/adam_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_adam_ctrl.sv

// ==== dv/tb_adam_ctrl.sv ====
/* Controller port testbench */
module tb_adam_ctrl;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int NUM_PLAYERS   = 2;
        localparam int CLK_PERIOD_NS = 40;
        localparam int RESET_CYCLES  = 10;
        localparam int NUM_PHASES    = 5;
        localparam int PHASE_CYCLES  = 2000;
        localparam int RAND_CYCLES   = 400;
        localparam int TIMEOUT_NS    = (NUM_PHASES * PHASE_CYCLES + RESET_CYCLES) * CLK_PERIOD_NS;

        // Scan codes indexed by digit
        localparam logic [7:0] MAIN_ROW [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
                                                 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
        localparam logic [7:0] KEYPAD [10]   = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B,
                                                 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D};

        logic                   clk_sys;
        logic                   rst_n;
        logic [31:0]            joy0;
        logic [31:0]            joy1;
        logic                   swap;
        logic [10:0]            ps2_key;
        logic [NUM_PLAYERS-1:0] p5;
        logic [NUM_PLAYERS-1:0] p8;
        logic [NUM_PLAYERS-1:0] p1;
        logic [NUM_PLAYERS-1:0] p2;
        logic [NUM_PLAYERS-1:0] p3;
        logic [NUM_PLAYERS-1:0] p4;
        logic [NUM_PLAYERS-1:0] p6;

        // Reference keyboard state, one cycle behind the event
        logic [9:0]             ref_digit;
        logic                   ref_star;
        logic                   ref_minus;
        logic                   ref_shift;
        logic [4:0]             exp_port [NUM_PLAYERS];

        tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
                .clk_sys (clk_sys),
                .rst_n_o (rst_n)
        );

        adam_ctrl_top #(.NUM_PLAYERS(NUM_PLAYERS)) UUT (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n),
                .joy0_i    (joy0),
                .joy1_i    (joy1),
                .swap_i    (swap),
                .ps2_key_i (ps2_key),
                .ctrl_p5_i (p5),
                .ctrl_p8_i (p8),
                .ctrl_p1_o (p1),
                .ctrl_p2_o (p2),
                .ctrl_p3_o (p3),
                .ctrl_p4_o (p4),
                .ctrl_p6_o (p6)
        );

        // ========================================================================
        // Reference model
        // ========================================================================

        // Keypad code by vector index: digits, star, number, purple, blue
        function automatic logic [3:0] code_of(input int idx);
                case (idx)
                        0:       return 4'b0011;
                        1:       return 4'b1110;
                        2:       return 4'b1101;
                        3:       return 4'b0110;
                        4:       return 4'b0001;
                        5:       return 4'b1001;
                        6:       return 4'b0111;
                        7:       return 4'b1100;
                        8:       return 4'b1000;
                        9:       return 4'b1011;
                        10:      return 4'b1010;
                        11:      return 4'b0101;
                        12:      return 4'b0100;
                        13:      return 4'b0010;
                        default: return 4'b1111;
                endcase
        endfunction

        // Returns {p1, p2, p3, p4, p6}
        function automatic logic [4:0] expect_port(input logic [31:0] joy, input logic [9:0] dig,
                                                    input logic star, input logic minus,
                                                    input logic shift, input logic sel_kp_n,
                                                    input logic sel_joy_n);
                logic [13:0] kp;
                logic [3:0]  code;
                logic [3:0]  dir;
                logic        found;
                logic        fire_kp;
                logic        fire_joy;
                kp[9:0] = joy[17:8] | dig;
                kp[10]  = joy[6] | star | (dig[8] & shift);
                kp[11]  = joy[7] | minus | (dig[3] & shift);
                kp[12]  = joy[18];
                kp[13]  = joy[19];
                code    = 4'b1111;
                found   = 1'b0;
                for (int i = 0; i < 14; i++) begin
                        if (kp[i] && !found) begin
                                code  = code_of(i);
                                found = 1'b1;
                        end
                end
                fire_kp  = sel_kp_n ? 1'b1 : ~joy[5];
                code     = sel_kp_n ? 4'b1111 : code;
                fire_joy = sel_joy_n ? 1'b1 : ~joy[4];
                dir      = sel_joy_n ? 4'b1111 : ~{joy[3], joy[2], joy[1], joy[0]};
                return {code & dir, fire_kp & fire_joy};
        endfunction

        always_comb begin
                logic [31:0] stick;
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                        if (p == 0) begin
                                stick = swap ? joy1 : joy0;
                        end else if (p == 1) begin
                                stick = swap ? joy0 : joy1;
                        end else begin
                                stick = joy1;
                        end
                        exp_port[p] = expect_port(stick, ref_digit, ref_star, ref_minus,
                                                  ref_shift, p5[p], p8[p]);
                end
        end

        // ========================================================================
        // Checks
        // ========================================================================

        task automatic report_mismatch(input string name, input int p, input logic exp_v,
                                       input logic act_v);
                $display("** Error at %0d ns: %s[%0d] expected %b, actual %b",
                         $time, name, p, exp_v, act_v);
                $display("Verification failed");
                $fatal(1, "Port line mismatch");
        endtask

        for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_check
                a_p1: assert property (@(posedge clk_sys) disable iff (!rst_n)
                        p1[p] == exp_port[p][4])
                        else report_mismatch("ctrl_p1_o", p, $sampled(exp_port[p][4]),
                                             $sampled(p1[p]));
                a_p2: assert property (@(posedge clk_sys) disable iff (!rst_n)
                        p2[p] == exp_port[p][3])
                        else report_mismatch("ctrl_p2_o", p, $sampled(exp_port[p][3]),
                                             $sampled(p2[p]));
                a_p3: assert property (@(posedge clk_sys) disable iff (!rst_n)
                        p3[p] == exp_port[p][2])
                        else report_mismatch("ctrl_p3_o", p, $sampled(exp_port[p][2]),
                                             $sampled(p3[p]));
                a_p4: assert property (@(posedge clk_sys) disable iff (!rst_n)
                        p4[p] == exp_port[p][1])
                        else report_mismatch("ctrl_p4_o", p, $sampled(exp_port[p][1]),
                                             $sampled(p4[p]));
                a_p6: assert property (@(posedge clk_sys) disable iff (!rst_n)
                        p6[p] == exp_port[p][0])
                        else report_mismatch("ctrl_p6_o", p, $sampled(exp_port[p][0]),
                                             $sampled(p6[p]));
        end

        // ========================================================================
        // Stimulus
        // ========================================================================

        function automatic int scan_to_digit(input logic [7:0] code);
                int digit;
                digit = -1;
                for (int d = 0; d < 10; d++) begin
                        if (code == MAIN_ROW[d] || code == KEYPAD[d]) begin
                                digit = d;
                        end
                end
                return digit;
        endfunction

        // Sparse words so that an empty keypad vector comes up often
        function automatic logic [31:0] sparse_word();
                return $urandom() & $urandom() & $urandom();
        endfunction

        task automatic wait_cycles(input int n);
                repeat (n) @(posedge clk_sys);
        endtask

        // Event goes out on one edge, the model follows on the next
        task automatic send_key(input logic [7:0] code, input logic pressed);
                int d;
                @(posedge clk_sys);
                ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
                @(posedge clk_sys);
                d = scan_to_digit(code);
                if (d >= 0) begin
                        ref_digit[d] <= pressed;
                end else if (code == 8'h7C) begin
                        ref_star <= pressed;
                end else if (code == 8'h7B) begin
                        ref_minus <= pressed;
                end else if (code == 8'h12 || code == 8'h59) begin
                        ref_shift <= pressed;
                end
        endtask

        task automatic press_release(input logic [7:0] code);
                send_key(code, 1'b1);
                wait_cycles(3);
                send_key(code, 1'b0);
                wait_cycles(2);
        endtask

        task automatic drive_random(input int cycles);
                logic [31:0] sel_bits;
                repeat (cycles) begin
                        @(posedge clk_sys);
                        sel_bits = $urandom();
                        joy0 <= sparse_word();
                        joy1 <= sparse_word();
                        p5   <= sel_bits[NUM_PLAYERS-1:0];
                        p8   <= sel_bits[2*NUM_PLAYERS-1:NUM_PLAYERS];
                end
        endtask

        initial begin
                joy0      <= '0;
                joy1      <= '0;
                swap      <= 1'b0;
                ps2_key   <= '0;
                p5        <= '1;
                p8        <= '1;
                ref_digit <= '0;
                ref_star  <= 1'b0;
                ref_minus <= 1'b0;
                ref_shift <= 1'b0;
                void'($urandom(32'ha21e));
                wait (rst_n === 1'b1);

                // Idle port, then keypad half with nothing pressed
                wait_cycles(5);
                @(posedge clk_sys);
                p5 <= '0;
                wait_cycles(5);

                drive_random(RAND_CYCLES);

                @(posedge clk_sys);
                swap <= 1'b1;
                drive_random(RAND_CYCLES);
                @(posedge clk_sys);
                swap <= 1'b0;

                // Keyboard digits on an otherwise idle keypad half
                @(posedge clk_sys);
                joy0 <= '0;
                joy1 <= '0;
                p5   <= '0;
                p8   <= '1;
                for (int d = 0; d < 10; d++) begin
                        press_release(MAIN_ROW[d]);
                        press_release(KEYPAD[d]);
                end
                send_key(MAIN_ROW[7], 1'b1);
                send_key(KEYPAD[2], 1'b1);
                wait_cycles(3);
                send_key(KEYPAD[2], 1'b0);
                send_key(MAIN_ROW[7], 1'b0);

                // Shifted star and number with both halves selected
                @(posedge clk_sys);
                joy0 <= 32'h0000_0005;
                joy1 <= 32'h0000_0030;
                p8   <= '0;
                send_key(8'h12, 1'b1);
                press_release(MAIN_ROW[8]);
                press_release(MAIN_ROW[3]);
                send_key(8'h12, 1'b0);
                send_key(8'h59, 1'b1);
                press_release(KEYPAD[8]);
                press_release(KEYPAD[3]);
                send_key(8'h59, 1'b0);
                press_release(8'h7B);
                press_release(8'h7C);

                wait_cycles(4);
                $display("Verification passed");
                $finish;
        end

        initial begin
                #(TIMEOUT_NS);
                $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
                $display("Verification failed");
                $fatal(1, "Watchdog expired");
        end

endmodule

// ==== dv/tb_clk_gen.sv ====
/* Testbench clock and reset */
module tb_clk_gen #(
        parameter int PERIOD_NS    = 40,
        parameter int RESET_CYCLES = 10
) (
        output logic clk_sys,
        output logic rst_n_o
);
        timeunit 1ns;
        timeprecision 100ps;

        initial begin
                clk_sys <= 1'b0;
                forever #(PERIOD_NS / 2) clk_sys <= ~clk_sys;
        end

        // Release on a rising edge like any other input
        initial begin
                rst_n_o <= 1'b0;
                repeat (RESET_CYCLES) @(posedge clk_sys);
                rst_n_o <= 1'b1;
        end

endmodule

// ==== hw/adam_ctrl_pkg.sv ====
/* Controller port definitions */
package adam_ctrl_pkg;

        // Raw joystick word from the host
        typedef logic [31:0] joy_t;

        // Joystick bit positions
        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_NUMBER = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PURPLE = 18;
        localparam int JOY_BLUE   = 19;

        // Keyboard buttons: digits 0 to 9, then star and number
        localparam int NUM_DIGITS = 10;
        localparam int KB_STAR    = 10;
        localparam int KB_NUMBER  = 11;
        localparam int KB_WIDTH   = 12;
        typedef logic [KB_WIDTH-1:0] kb_btn_t;

        // Priority keypad vector adds the two triggers
        localparam int KEYPAD_W = 14;

        localparam int NUM_PLAYERS_DEF = 2;

        // Codes driven on p1..p4 while the keypad half is selected
        typedef enum logic [3:0] {
                KEY_0      = 4'b0011,
                KEY_1      = 4'b1110,
                KEY_2      = 4'b1101,
                KEY_3      = 4'b0110,
                KEY_4      = 4'b0001,
                KEY_5      = 4'b1001,
                KEY_6      = 4'b0111,
                KEY_7      = 4'b1100,
                KEY_8      = 4'b1000,
                KEY_9      = 4'b1011,
                KEY_STAR   = 4'b1010,
                KEY_NUMBER = 4'b0101,
                KEY_PURPLE = 4'b0100,
                KEY_BLUE   = 4'b0010,
                KEY_NONE   = 4'b1111
        } cv_key_e;

        // Code for each keypad vector bit, lowest index has priority
        localparam cv_key_e KEY_ORDER [KEYPAD_W] = '{
                KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
                KEY_STAR, KEY_NUMBER, KEY_PURPLE, KEY_BLUE
        };

endpackage

// ==== hw/adam_ctrl_top.sv ====
/* Controller port top */
module adam_ctrl_top #(
        parameter int NUM_PLAYERS = adam_ctrl_pkg::NUM_PLAYERS_DEF
) (
        input  logic                   clk_sys,
        input  logic                   rst_n_i,
        input  adam_ctrl_pkg::joy_t    joy0_i,
        input  adam_ctrl_pkg::joy_t    joy1_i,
        input  logic                   swap_i,
        input  ps2_key_pkg::ps2_key_t  ps2_key_i,
        input  logic [NUM_PLAYERS-1:0] ctrl_p5_i,
        input  logic [NUM_PLAYERS-1:0] ctrl_p8_i,
        output logic [NUM_PLAYERS-1:0] ctrl_p1_o,
        output logic [NUM_PLAYERS-1:0] ctrl_p2_o,
        output logic [NUM_PLAYERS-1:0] ctrl_p3_o,
        output logic [NUM_PLAYERS-1:0] ctrl_p4_o,
        output logic [NUM_PLAYERS-1:0] ctrl_p6_o
);
        import adam_ctrl_pkg::*;

        kb_btn_t kb_btn;
        joy_t    joy_sel [NUM_PLAYERS];

        // One keyboard feeds every player
        ps2_keypad_emu u_keypad_emu (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n_i),
                .ps2_key_i (ps2_key_i),
                .kb_btn_o  (kb_btn)
        );

        // ========================================================================
        // Per-player ports
        // ========================================================================

        for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
                if (p == 0) begin : g_joy_a
                        assign joy_sel[p] = swap_i ? joy1_i : joy0_i;
                end else if (p == 1) begin : g_joy_b
                        assign joy_sel[p] = swap_i ? joy0_i : joy1_i;
                end else begin : g_joy_extra
                        // Extra players share the second stick
                        assign joy_sel[p] = joy1_i;
                end

                ctrl_port_encoder u_encoder (
                        .clk_sys        (clk_sys),
                        .rst_n_i        (rst_n_i),
                        .joy_i          (joy_sel[p]),
                        .kb_btn_i       (kb_btn),
                        .sel_keypad_n_i (ctrl_p5_i[p]),
                        .sel_joy_n_i    (ctrl_p8_i[p]),
                        .ctrl_p1_o      (ctrl_p1_o[p]),
                        .ctrl_p2_o      (ctrl_p2_o[p]),
                        .ctrl_p3_o      (ctrl_p3_o[p]),
                        .ctrl_p4_o      (ctrl_p4_o[p]),
                        .ctrl_p6_o      (ctrl_p6_o[p])
                );
        end

endmodule

// ==== hw/ctrl_port_encoder.sv ====
/* Controller port encoder */
module ctrl_port_encoder (
        input  logic                   clk_sys,
        input  logic                   rst_n_i,
        input  adam_ctrl_pkg::joy_t    joy_i,
        input  adam_ctrl_pkg::kb_btn_t kb_btn_i,
        input  logic                   sel_keypad_n_i,
        input  logic                   sel_joy_n_i,
        output logic                   ctrl_p1_o,
        output logic                   ctrl_p2_o,
        output logic                   ctrl_p3_o,
        output logic                   ctrl_p4_o,
        output logic                   ctrl_p6_o
);
        import adam_ctrl_pkg::*;

        logic [KEYPAD_W-1:0] keypad_s;
        cv_key_e             key_code_s;
        logic [3:0]          code_part_s;
        logic [3:0]          dir_part_s;
        logic                kp_fire_s;
        logic                joy_fire_s;

        // ========================================================================
        // Keypad half
        // ========================================================================

        // Digits 0..9, star, number, purple, blue from bit 0 upward
        assign keypad_s = {
                joy_i[JOY_BLUE],
                joy_i[JOY_PURPLE],
                joy_i[JOY_NUMBER] | kb_btn_i[KB_NUMBER],
                joy_i[JOY_STAR] | kb_btn_i[KB_STAR],
                joy_i[JOY_DIGIT0 +: NUM_DIGITS] | kb_btn_i[NUM_DIGITS-1:0]
        };

        // Lowest set bit wins, so walk from the top down
        always_comb begin
                key_code_s = KEY_NONE;
                for (int i = KEYPAD_W - 1; i >= 0; i--) begin
                        if (keypad_s[i]) begin
                                key_code_s = KEY_ORDER[i];
                        end
                end
        end

        assign code_part_s = sel_keypad_n_i ? 4'b1111 : key_code_s;
        assign kp_fire_s   = sel_keypad_n_i ? 1'b1 : ~joy_i[JOY_FIRE2];

        // ========================================================================
        // Joystick half
        // ========================================================================

        // p1..p4 carry up, down, left, right
        assign dir_part_s = sel_joy_n_i ? 4'b1111 :
                            ~{joy_i[JOY_UP], joy_i[JOY_DOWN], joy_i[JOY_LEFT], joy_i[JOY_RIGHT]};
        assign joy_fire_s = sel_joy_n_i ? 1'b1 : ~joy_i[JOY_FIRE1];

        // Both halves pull the shared lines low
        assign {ctrl_p1_o, ctrl_p2_o, ctrl_p3_o, ctrl_p4_o} = code_part_s & dir_part_s;
        assign ctrl_p6_o = kp_fire_s & joy_fire_s;

        // ========================================================================
        // Checks
        // ========================================================================

        // Idle port reads all ones
        a_idle_high: assert property (
                @(posedge clk_sys) disable iff (!rst_n_i)
                (sel_keypad_n_i && sel_joy_n_i) |->
                        &{ctrl_p1_o, ctrl_p2_o, ctrl_p3_o, ctrl_p4_o, ctrl_p6_o}
        );

        a_legal_code: assert property (
                @(posedge clk_sys) disable iff (!rst_n_i)
                code_part_s inside {KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6,
                                    KEY_7, KEY_8, KEY_9, KEY_STAR, KEY_NUMBER,
                                    KEY_PURPLE, KEY_BLUE, KEY_NONE}
        );

endmodule

// ==== hw/ps2_key_pkg.sv ====
/* PS/2 key event definitions */
package ps2_key_pkg;

        // toggle, pressed, extended, scan code[7:0]
        typedef logic [10:0] ps2_key_t;

        localparam int PS2_TOGGLE  = 10;
        localparam int PS2_PRESSED = 9;
        localparam int PS2_CODE_W  = 8;

        // Scan codes used by the keypad emulation
        typedef enum logic [7:0] {
                // Main row
                SC_1        = 8'h16,
                SC_2        = 8'h1E,
                SC_3        = 8'h26,
                SC_4        = 8'h25,
                SC_5        = 8'h2E,
                SC_6        = 8'h36,
                SC_7        = 8'h3D,
                SC_8        = 8'h3E,
                SC_9        = 8'h46,
                SC_0        = 8'h45,
                // Numeric keypad
                SC_KP1      = 8'h69,
                SC_KP2      = 8'h72,
                SC_KP3      = 8'h7A,
                SC_KP4      = 8'h6B,
                SC_KP5      = 8'h73,
                SC_KP6      = 8'h74,
                SC_KP7      = 8'h6C,
                SC_KP8      = 8'h75,
                SC_KP9      = 8'h7D,
                SC_KP0      = 8'h70,
                SC_KP_STAR  = 8'h7C,
                SC_KP_MINUS = 8'h7B,
                SC_RSHIFT   = 8'h59,
                SC_LSHIFT   = 8'h12
        } ps2_code_e;

endpackage

// ==== hw/ps2_keypad_emu.sv ====
/* PS/2 keypad emulation */
module ps2_keypad_emu (
        input  logic                   clk_sys,
        input  logic                   rst_n_i,
        input  ps2_key_pkg::ps2_key_t  ps2_key_i,
        output adam_ctrl_pkg::kb_btn_t kb_btn_o
);
        import adam_ctrl_pkg::*;
        import ps2_key_pkg::*;

        logic                toggle_q;
        logic                event_s;
        logic                pressed_s;
        ps2_code_e           code_s;
        logic [KB_WIDTH-1:0] held_q;    // star bit holds star key, number bit holds minus
        logic                shift_q;

        // New event whenever the toggle differs from last edge
        assign event_s   = ps2_key_i[PS2_TOGGLE] != toggle_q;
        assign pressed_s = ps2_key_i[PS2_PRESSED];
        // Extended flag is not part of the match
        assign code_s    = ps2_code_e'(ps2_key_i[PS2_CODE_W-1:0]);

        // ========================================================================
        // Held-button state
        // ========================================================================

        always_ff @(posedge clk_sys or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        toggle_q <= 1'b0;
                        held_q   <= '0;
                        shift_q  <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i[PS2_TOGGLE];
                        if (event_s) begin
                                case (code_s)
                                        SC_0, SC_KP0:           held_q[0] <= pressed_s;
                                        SC_1, SC_KP1:           held_q[1] <= pressed_s;
                                        SC_2, SC_KP2:           held_q[2] <= pressed_s;
                                        SC_3, SC_KP3:           held_q[3] <= pressed_s;
                                        SC_4, SC_KP4:           held_q[4] <= pressed_s;
                                        SC_5, SC_KP5:           held_q[5] <= pressed_s;
                                        SC_6, SC_KP6:           held_q[6] <= pressed_s;
                                        SC_7, SC_KP7:           held_q[7] <= pressed_s;
                                        SC_8, SC_KP8:           held_q[8] <= pressed_s;
                                        SC_9, SC_KP9:           held_q[9] <= pressed_s;
                                        SC_KP_STAR:             held_q[KB_STAR] <= pressed_s;
                                        SC_KP_MINUS:            held_q[KB_NUMBER] <= pressed_s;
                                        SC_LSHIFT, SC_RSHIFT:   shift_q <= pressed_s;
                                        default: ;
                                endcase
                        end
                end
        end

        // Shift+8 reads as star, shift+3 as number
        always_comb begin
                kb_btn_o            = held_q;
                kb_btn_o[KB_STAR]   = held_q[KB_STAR] | (held_q[8] & shift_q);
                kb_btn_o[KB_NUMBER] = held_q[KB_NUMBER] | (held_q[3] & shift_q);
        end

        // ========================================================================
        // Checks
        // ========================================================================

        // Nothing may be held in the first cycle out of reset
        a_clear_after_reset: assert property (
                @(posedge clk_sys) $rose(rst_n_i) |-> ({held_q, shift_q} == '0)
        );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the controller port testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_adam_ctrl -f all.f -o sim_tb

# The simulator status is not used, the log decides
./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "Verification passed" "$LOG"; then
        echo "Simulation PASSED"
        exit 0
else
        echo "Simulation FAILED, see $LOG"
        exit 1
fi
